// ==== Bender.yml ====
package:
  name: fm_mix

sources:
  - design/fm_mix_pkg.sv
  - design/fm_slot_if.sv
  - design/fm_mix_regs.sv
  - design/fm_slot_select.sv
  - design/fm_chan_accum.sv
  - design/fm_stereo_mix.sv
  - design/fm_float_dac.sv
  - design/fm_mix_top.sv
  - target: simulation
    files:
      - verification/fm_mix_tb.sv

// ==== design/fm_chan_accum.sv ====
////////////////////
// One running sum per channel, started at M1 and emitted at C2
////////////////////
`default_nettype none

module fm_chan_accum (
	input  logic   clk,
	input  logic   rst_sum,
	fm_slot_if.dst in,
	fm_slot_if.src out
);
	import fm_mix_pkg::*;

	logic signed [acc_width-1:0] sums [num_chan];  // Partial sums
	logic signed [acc_width-1:0] cur_sum;
	logic signed [acc_width-1:0] nxt_sum;
	logic                        is_c2;

	assign cur_sum = sums[in.chan];
	assign is_c2   = in.valid && (in.grp == grp_c2);

	always_comb begin
		if (in.grp == grp_m1)
			nxt_sum = in.carrier ? in.value : '0;    // Start of the channel
		else if (in.carrier)
			nxt_sum = sat_add(cur_sum, in.value);
		else
			nxt_sum = cur_sum;                       // Modulator only
	end

	always_ff @(posedge clk) begin
		if (in.valid)
			sums[in.chan] <= nxt_sum;
	end

	always_ff @(posedge clk) begin
		if (rst_sum) begin
			out.valid <= 1'b0;
			out.last  <= 1'b0;
		end else begin
			out.valid <= is_c2;
			out.last  <= is_c2 && in.last;               // Channel 7 closes the frame
		end
	end

	// Channel sum payload
	always_ff @(posedge clk) begin
		if (is_c2) begin
			out.chan    <= in.chan;
			out.grp     <= grp_c2;
			out.carrier <= in.carrier;
			out.value   <= nxt_sum;
		end
	end

	// Each sum follows a C2 sample and C2 is always a carrier
	a_sum_after_c2: assert property (@(posedge clk) disable iff (rst_sum)
		out.valid |-> $past(in.valid && in.grp == grp_c2 && in.carrier));

endmodule

`default_nettype wire

// ==== design/fm_float_dac.sv ====
////////////////////
// Outputs hold between frames and change only with frame_valid
////////////////////
`default_nettype none

module fm_float_dac (
	input  logic                                    clk,
	input  logic                                    rst_sum,
	input  logic                                    frame_done,
	input  logic signed [fm_mix_pkg::acc_width-1:0] xleft_in,
	input  logic signed [fm_mix_pkg::acc_width-1:0] xright_in,
	output logic signed [fm_mix_pkg::acc_width-1:0] left,
	output logic signed [fm_mix_pkg::acc_width-1:0] right,
	output logic signed [fm_mix_pkg::acc_width-1:0] xleft,
	output logic signed [fm_mix_pkg::acc_width-1:0] xright,
	output logic [fm_mix_pkg::man_width-1:0]        left_man,
	output logic [fm_mix_pkg::man_width-1:0]        right_man,
	output logic [fm_mix_pkg::exp_width-1:0]        left_exp,
	output logic [fm_mix_pkg::exp_width-1:0]        right_exp,
	output logic                                    frame_valid
);
	import fm_mix_pkg::*;

	logic [exp_width+man_width-1:0] left_c;
	logic [exp_width+man_width-1:0] right_c;

	// Smallest shift that fits the mantissa, result is {exp, man}
	function automatic logic [exp_width+man_width-1:0] compress(
		input logic signed [acc_width-1:0] v
	);
		logic signed [acc_width-1:0] sh;
		logic [exp_width-1:0]        e;
		logic                        found;
		e     = exp_width'(max_exp);
		found = 1'b0;
		for (int i = 0; i <= max_exp; i++) begin
			sh = v >>> i;
			if (!found && ((&sh[acc_width-1:man_width-1]) || !(|sh[acc_width-1:man_width-1]))) begin
				e     = exp_width'(i);
				found = 1'b1;
			end
		end
		sh = v >>> e;
		return {e, sh[man_width-1:0]};
	endfunction

	// Sign extend and scale back up
	function automatic logic signed [acc_width-1:0] expand(
		input logic [exp_width+man_width-1:0] c
	);
		logic signed [acc_width-1:0] ext;
		ext = {{(acc_width-man_width){c[man_width-1]}}, c[man_width-1:0]};
		return ext <<< c[exp_width+man_width-1:man_width];
	endfunction

	assign left_c  = compress(xleft_in);
	assign right_c = compress(xright_in);

	always_ff @(posedge clk) begin
		if (rst_sum) begin
			frame_valid <= 1'b0;
			{left, right, xleft, xright} <= '0;
			{left_man, right_man, left_exp, right_exp} <= '0;
		end else begin
			frame_valid <= frame_done;               // One cycle pulse
			if (frame_done) begin
				{left_exp, left_man}   <= left_c;
				{right_exp, right_man} <= right_c;
				left   <= expand(left_c);
				right  <= expand(right_c);
				xleft  <= xleft_in;                  // Exact pair passes through
				xright <= xright_in;
			end
		end
	end

	a_exp_range: assert property (@(posedge clk) disable iff (rst_sum)
		left_exp <= exp_width'(max_exp) && right_exp <= exp_width'(max_exp));

	// Frames are 32 slots apart so the pulse never repeats
	a_valid_pulse: assert property (@(posedge clk) disable iff (rst_sum)
		frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// ==== design/fm_mix_pkg.sv ====
////////////////////
// Constants for the 8 channel FM output mixer. Slot order is M1, M2, C1, C2
// in groups of eight channels, so the group is slot / 8 and the channel is slot mod 8
////////////////////
`default_nettype none

package fm_mix_pkg;

	localparam int num_chan    = 8;                  // Channels per frame
	localparam int num_slots   = 32;                 // Operator slots per frame
	localparam int chan_width  = $clog2(num_chan);   // Channel field of the slot number
	localparam int slot_width  = $clog2(num_slots);  // Slot counter width
	localparam int op_width    = 14;                 // Signed operator sample
	localparam int noise_width = 10;                 // Signed noise sample
	localparam int acc_width   = 16;                 // Sums and outputs
	localparam int man_width   = 10;                 // DAC mantissa
	localparam int exp_width   = 3;                  // DAC exponent
	localparam int max_exp     = 6;

	localparam logic [7:0] reg_noise_addr = 8'h20;   // Control register, channels below it

	// Operator group of a slot, in stream order
	typedef enum logic [1:0] {
		grp_m1 = 2'd0,
		grp_m2 = 2'd1,
		grp_c1 = 2'd2,
		grp_c2 = 2'd3
	} op_grp_e;

	// 16 bit signed add clamped to the largest or smallest value
	function automatic logic signed [acc_width-1:0] sat_add(
		input logic signed [acc_width-1:0] a,
		input logic signed [acc_width-1:0] b
	);
		logic signed [acc_width:0] s;
		s = a + b;                                    // One guard bit
		if (s[acc_width] != s[acc_width-1])
			return s[acc_width] ? {1'b1, {(acc_width-1){1'b0}}} : {1'b0, {(acc_width-1){1'b1}}};
		return s[acc_width-1:0];
	endfunction

endpackage

`default_nettype wire

// ==== design/fm_mix_regs.sv ====
////////////////////
// APB slave with no wait states. Unaligned or out of range accesses give pslverr
// and read back zero
////////////////////
`default_nettype none

module fm_mix_regs (
	input  logic                              clk,
	input  logic                              rst_sum,
	input  logic [7:0]                        paddr,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic [fm_mix_pkg::num_chan-1:0][2:0] con_tbl,
	output logic [fm_mix_pkg::num_chan-1:0][1:0] rl_tbl,
	output logic                              noise_en
);
	import fm_mix_pkg::*;

	logic                  addr_ok;
	logic                  is_ctrl;
	logic [chan_width-1:0] reg_chan;
	logic                  access;

	assign addr_ok  = (paddr[1:0] == 2'b00) && (paddr <= reg_noise_addr);
	assign is_ctrl  = (paddr == reg_noise_addr);
	assign reg_chan = paddr[chan_width+1:2];       // Byte address / 4
	assign access   = psel && penable;
	assign pready   = 1'b1;
	assign pslverr  = access && !addr_ok;

	always_comb begin
		prdata = 32'd0;
		if (psel && !pwrite && addr_ok) begin
			if (is_ctrl)
				prdata[0] = noise_en;
			else
				prdata[4:0] = {rl_tbl[reg_chan], con_tbl[reg_chan]}; // Pan over algorithm
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sum) begin
			con_tbl  <= '0;
			rl_tbl   <= '0;
			noise_en <= 1'b0;
		end else if (access && pwrite && addr_ok) begin
			if (is_ctrl) begin
				noise_en <= pwdata[0];
			end else begin
				con_tbl[reg_chan] <= pwdata[2:0];
				rl_tbl[reg_chan]  <= pwdata[4:3];      // Bit 3 left, bit 4 right
			end
		end
	end

	// Error only in an access phase that follows its setup phase
	a_slverr_access: assert property (@(posedge clk) disable iff (rst_sum)
		pslverr |-> psel && penable && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== design/fm_mix_top.sv ====
////////////////////
// Operator stream has no back-pressure. Slot 31 to frame_valid is 4 cycles
////////////////////
`default_nettype none

module fm_mix_top (
	input  logic                                      clk,
	input  logic                                      rst_sum,
	input  logic [7:0]                                paddr,
	input  logic                                      psel,
	input  logic                                      penable,
	input  logic                                      pwrite,
	input  logic [31:0]                               pwdata,
	output logic [31:0]                               prdata,
	output logic                                      pready,
	output logic                                      pslverr,
	input  logic                                      op_valid,
	input  logic signed [fm_mix_pkg::op_width-1:0]    op_value,
	input  logic signed [fm_mix_pkg::noise_width-1:0] noise,
	output logic signed [fm_mix_pkg::acc_width-1:0]   left,
	output logic signed [fm_mix_pkg::acc_width-1:0]   right,
	output logic signed [fm_mix_pkg::acc_width-1:0]   xleft,
	output logic signed [fm_mix_pkg::acc_width-1:0]   xright,
	output logic [fm_mix_pkg::man_width-1:0]          left_man,
	output logic [fm_mix_pkg::exp_width-1:0]          left_exp,
	output logic [fm_mix_pkg::man_width-1:0]          right_man,
	output logic [fm_mix_pkg::exp_width-1:0]          right_exp,
	output logic                                      frame_valid
);
	import fm_mix_pkg::*;

	logic [num_chan-1:0][2:0]    con_tbl;         // Algorithm per channel
	logic [num_chan-1:0][1:0]    rl_tbl;          // Pan per channel
	logic                        noise_en;
	logic                        frame_done;
	logic signed [acc_width-1:0] mix_xleft;
	logic signed [acc_width-1:0] mix_xright;

	fm_slot_if s1_if ();                          // Tagged slot samples
	fm_slot_if s2_if ();                          // Channel sums

	fm_mix_regs u_regs (
		.clk, .rst_sum,
		.paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr,
		.con_tbl, .rl_tbl, .noise_en
	);

	fm_slot_select u_select (
		.clk, .rst_sum,
		.op_valid, .op_value, .noise, .noise_en, .con_tbl,
		.out (s1_if.src)
	);

	fm_chan_accum u_accum (
		.clk, .rst_sum,
		.in  (s1_if.dst),
		.out (s2_if.src)
	);

	fm_stereo_mix u_mix (
		.clk, .rst_sum,
		.in         (s2_if.dst),
		.rl_tbl,
		.frame_done,
		.xleft      (mix_xleft),
		.xright     (mix_xright)
	);

	fm_float_dac u_dac (
		.clk, .rst_sum,
		.frame_done,
		.xleft_in  (mix_xleft),
		.xright_in (mix_xright),
		.left, .right, .xleft, .xright,
		.left_man, .right_man, .left_exp, .right_exp,
		.frame_valid
	);

endmodule

`default_nettype wire

// ==== design/fm_slot_if.sv ====
////////////////////
// Slot sample between pipeline stages. No ready, a sample moves whenever valid is high
////////////////////
`default_nettype none

interface fm_slot_if;
	import fm_mix_pkg::*;

	logic                        valid;    // Sample present this cycle
	logic [chan_width-1:0]       chan;
	op_grp_e                     grp;      // Always c2 for channel sums
	logic                        carrier;  // Sample counts toward the channel sum
	logic signed [acc_width-1:0] value;
	logic                        last;     // Slot 31, or channel 7 sum

	modport src (output valid, chan, grp, carrier, value, last);
	modport dst (input valid, chan, grp, carrier, value, last);

endinterface

`default_nettype wire

// ==== design/fm_slot_select.sv ====
////////////////////
// Stream starts at slot 0 after reset. Only accepted samples advance the slot
////////////////////
`default_nettype none

module fm_slot_select (
	input  logic                                      clk,
	input  logic                                      rst_sum,
	input  logic                                      op_valid,
	input  logic signed [fm_mix_pkg::op_width-1:0]    op_value,
	input  logic signed [fm_mix_pkg::noise_width-1:0] noise,
	input  logic                                      noise_en,
	input  logic [fm_mix_pkg::num_chan-1:0][2:0]      con_tbl,
	fm_slot_if.src                                    out
);
	import fm_mix_pkg::*;

	logic [slot_width-1:0]      slot_cnt;
	logic [chan_width-1:0]      slot_chan;
	op_grp_e                    slot_grp;
	logic                       slot_last;
	logic signed [op_width-1:0] op_val;
	logic                       is_carrier;

	assign slot_chan = slot_cnt[chan_width-1:0];
	assign slot_grp  = op_grp_e'(slot_cnt[slot_width-1:chan_width]);
	assign slot_last = (slot_cnt == slot_width'(num_slots - 1));

	// Noise replaces the last operator of the frame
	assign op_val = (noise_en && slot_last) ?
		{noise, {(op_width-noise_width){1'b0}}} : op_value;

	always_comb begin
		case (con_tbl[slot_chan])
			3'd0, 3'd1, 3'd2, 3'd3: is_carrier = (slot_grp == grp_c2);
			3'd4:                   is_carrier = (slot_grp == grp_m2) || (slot_grp == grp_c2);
			3'd5, 3'd6:             is_carrier = (slot_grp != grp_m1);
			default:                is_carrier = 1'b1;             // Algorithm 7
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_sum) begin
			slot_cnt  <= '0;
			out.valid <= 1'b0;
			out.last  <= 1'b0;
		end else begin
			out.valid <= op_valid;
			out.last  <= op_valid && slot_last;
			if (op_valid)
				slot_cnt <= slot_cnt + 1'b1;            // Wraps at frame end
		end
	end

	always_ff @(posedge clk) begin
		if (op_valid) begin
			out.chan    <= slot_chan;
			out.grp     <= slot_grp;
			out.carrier <= is_carrier;
			out.value   <= {{(acc_width-op_width){op_val[op_width-1]}}, op_val};
		end
	end

	a_last_slot: assert property (@(posedge clk) disable iff (rst_sum)
		out.last |-> out.valid && (out.chan == chan_width'(num_chan - 1)) && (out.grp == grp_c2));

endmodule

`default_nettype wire

// ==== design/fm_stereo_mix.sv ====
////////////////////
// Panning is read as each channel sum arrives. Channel 0 starts a new frame
////////////////////
`default_nettype none

module fm_stereo_mix (
	input  logic                                    clk,
	input  logic                                    rst_sum,
	fm_slot_if.dst                                  in,
	input  logic [fm_mix_pkg::num_chan-1:0][1:0]    rl_tbl,
	output logic                                    frame_done,
	output logic signed [fm_mix_pkg::acc_width-1:0] xleft,
	output logic signed [fm_mix_pkg::acc_width-1:0] xright
);
	import fm_mix_pkg::*;

	logic [1:0]                  pan;
	logic signed [acc_width-1:0] l_add;
	logic signed [acc_width-1:0] r_add;
	logic signed [acc_width-1:0] pre_left;
	logic signed [acc_width-1:0] pre_right;
	logic signed [acc_width-1:0] nxt_left;
	logic signed [acc_width-1:0] nxt_right;

	assign pan   = rl_tbl[in.chan];
	assign l_add = pan[0] ? in.value : '0;            // Left enable
	assign r_add = pan[1] ? in.value : '0;            // Right enable

	assign nxt_left  = (in.chan == '0) ? l_add : sat_add(pre_left, l_add);
	assign nxt_right = (in.chan == '0) ? r_add : sat_add(pre_right, r_add);

	always_ff @(posedge clk) begin
		if (in.valid) begin
			pre_left  <= nxt_left;
			pre_right <= nxt_right;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sum) begin
			frame_done <= 1'b0;
			xleft      <= '0;
			xright     <= '0;
		end else begin
			frame_done <= in.valid && in.last;
			if (in.valid && in.last) begin
				xleft  <= nxt_left;                      // Includes channel 7
				xright <= nxt_right;
			end
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/fm_mix_pkg.sv
design/fm_slot_if.sv
design/fm_mix_regs.sv
design/fm_slot_select.sv
design/fm_chan_accum.sv
design/fm_stereo_mix.sv
design/fm_float_dac.sv
design/fm_mix_top.sv
verification/fm_mix_tb.sv

// ==== verification/fm_mix_tb.sv ====
////////////////////
// Frames are sent one at a time and drained before each register change.
// Checks every output at frame_valid against a model of the mixing rules
////////////////////
`default_nettype none

module fm_mix_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fm_mix_pkg::*;

	logic                          clk = 1'b0;
	logic                          rst_sum;
	logic [7:0]                    paddr;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [31:0]                   pwdata;
	logic [31:0]                   prdata;
	logic                          pready;
	logic                          pslverr;
	logic                          op_valid;
	logic signed [op_width-1:0]    op_value;
	logic signed [noise_width-1:0] noise;
	logic signed [acc_width-1:0]   left;
	logic signed [acc_width-1:0]   right;
	logic signed [acc_width-1:0]   xleft;
	logic signed [acc_width-1:0]   xright;
	logic [man_width-1:0]          left_man;
	logic [exp_width-1:0]          left_exp;
	logic [man_width-1:0]          right_man;
	logic [exp_width-1:0]          right_exp;
	logic                          frame_valid;

	logic signed [op_width-1:0]    frame_ops [num_slots];  // Operator values of the next frame
	logic signed [noise_width-1:0] frame_noise;
	logic [2:0]                    con_m [num_chan];       // Configuration as written
	logic [1:0]                    rl_m [num_chan];
	logic                          noise_m;
	logic [31:0]                   exp_q [$];              // Expected {xleft, xright}
	int                            frames_sent = 0;

	fm_mix_top dut0 (.*);

	always #20 clk = ~clk;                                 // 40 ns period

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Run stopped on error");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] expd);
		stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, expd));
	endtask

	// Carrier flag per group with bit 0 for M1
	function automatic logic [3:0] carrier_mask(input logic [2:0] alg);
		case (alg)
			3'd4:       return 4'b1010;
			3'd5, 3'd6: return 4'b1110;
			3'd7:       return 4'b1111;
			default:    return 4'b1000;                    // C2 only
		endcase
	endfunction

	function automatic int clamp16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	// Exact stereo pair of the frame in frame_ops
	function automatic logic [31:0] mix_ref();
		int         sum;
		int         v;
		int         l;
		int         r;
		logic [3:0] mask;
		l = 0;
		r = 0;
		for (int ch = 0; ch < num_chan; ch++) begin
			sum  = 0;
			mask = carrier_mask(con_m[ch]);
			for (int g = 0; g < 4; g++) begin
				v = frame_ops[g * num_chan + ch];
				if (noise_m && g == 3 && ch == num_chan - 1)
					v = frame_noise * 16;                  // Noise in slot 31
				if (mask[g])
					sum = clamp16(sum + v);
			end
			if (rl_m[ch][0])
				l = clamp16(l + sum);
			if (rl_m[ch][1])
				r = clamp16(r + sum);
		end
		return {l[15:0], r[15:0]};
	endfunction

	// {exp, man, reconstruction} of one side
	function automatic logic [28:0] dac_ref(input logic signed [15:0] x);
		int v;
		int sh;
		int e;
		v  = x;
		e  = 0;
		sh = v;
		while (sh > 511 || sh < -512) begin
			e++;
			sh = v >>> e;
		end
		return {3'(e), 10'(sh), 16'(sh <<< e)};
	endfunction

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		input logic [31:0] rdata, input logic err);
		@(posedge clk);
		psel    <= 1'b1;                                   // Setup phase
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		assert (pready === 1'b1) else stop_run("pready was low in an APB access phase");
		assert (pslverr === err) else report_mismatch("pslverr", 16'(pslverr), 16'(err));
		if (!wr) begin
			assert (prdata === rdata)
			else stop_run($sformatf("FAILED at %0t: prdata is %h, expected %h",
				$time, prdata, rdata));
		end
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic set_chan(input int ch, input logic [2:0] alg, input logic [1:0] pan);
		apb_access(1'b1, 8'(ch * 4), {27'd0, pan, alg}, 32'd0, 1'b0);
		con_m[ch] = alg;
		rl_m[ch]  = pan;
	endtask

	task automatic set_noise(input logic en);
		apb_access(1'b1, reg_noise_addr, {31'd0, en}, 32'd0, 1'b0);
		noise_m = en;
	endtask

	// 32 slots with gaps of 0 to 2 cycles
	task automatic send_frame();
		int gap;
		exp_q.push_back(mix_ref());
		for (int s = 0; s < num_slots; s++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) begin
				@(posedge clk);
				op_valid <= 1'b0;
			end
			@(posedge clk);
			op_valid <= 1'b1;
			op_value <= frame_ops[s];
			noise    <= frame_noise;
		end
		@(posedge clk);
		op_valid <= 1'b0;
		frames_sent++;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
	endtask

	// Compare all outputs at each frame_valid
	initial begin
		logic [31:0] pair;
		logic [28:0] cl;
		logic [28:0] cr;
		forever begin
			@(negedge clk);
			if (frame_valid) begin
				assert (exp_q.size() > 0) else stop_run("frame_valid arrived with no frame pending");
				pair = exp_q.pop_front();
				cl   = dac_ref(pair[31:16]);
				cr   = dac_ref(pair[15:0]);
				assert (xleft === pair[31:16]) else report_mismatch("xleft", xleft, pair[31:16]);
				assert (xright === pair[15:0]) else report_mismatch("xright", xright, pair[15:0]);
				assert (left_exp === cl[28:26])
				else report_mismatch("left_exp", 16'(left_exp), 16'(cl[28:26]));
				assert (left_man === cl[25:16])
				else report_mismatch("left_man", 16'(left_man), 16'(cl[25:16]));
				assert (left === cl[15:0]) else report_mismatch("left", left, cl[15:0]);
				assert (right_exp === cr[28:26])
				else report_mismatch("right_exp", 16'(right_exp), 16'(cr[28:26]));
				assert (right_man === cr[25:16])
				else report_mismatch("right_man", 16'(right_man), 16'(cr[25:16]));
				assert (right === cr[15:0]) else report_mismatch("right", right, cr[15:0]);
			end
		end
	end

	// Watchdog scaled by the frames sent so far
	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > 200 * frames_sent + 2000)
				stop_run("Timeout: the run did not finish in the expected number of cycles");
		end
	end

	initial begin
		void'($urandom(32'h97a30201));
		rst_sum     = 1'b1;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		op_valid    = 1'b0;
		op_value    = '0;
		noise       = '0;
		noise_m     = 1'b0;
		frame_noise = '0;
		for (int ch = 0; ch < num_chan; ch++) begin
			con_m[ch] = '0;
			rl_m[ch]  = '0;
		end
		repeat (3) @(posedge clk);
		rst_sum <= 1'b0;

		apb_access(1'b1, 8'h0c, 32'h1d, 32'h0, 1'b0);     // Channel 3 read back
		apb_access(1'b0, 8'h0c, 32'h0, 32'h1d, 1'b0);
		apb_access(1'b1, 8'h20, 32'h1, 32'h0, 1'b0);
		apb_access(1'b0, 8'h20, 32'h0, 32'h1, 1'b0);
		apb_access(1'b1, 8'h20, 32'h0, 32'h0, 1'b0);
		apb_access(1'b1, 8'h24, 32'h1f, 32'h0, 1'b1);     // Out of range
		apb_access(1'b0, 8'h24, 32'h0, 32'h0, 1'b1);
		apb_access(1'b1, 8'h05, 32'h1f, 32'h0, 1'b1);     // Unaligned
		apb_access(1'b0, 8'h05, 32'h0, 32'h0, 1'b1);
		apb_access(1'b0, 8'h04, 32'h0, 32'h0, 1'b0);      // Channel 1 untouched
		apb_access(1'b0, 8'h20, 32'h0, 32'h0, 1'b0);
		apb_access(1'b1, 8'h0c, 32'h0, 32'h0, 1'b0);

		// One algorithm per frame with the channel under test on the left
		for (int a = 0; a < 8; a++) begin
			for (int ch = 0; ch < num_chan; ch++)
				set_chan(ch, 3'(a), (ch == a) ? 2'd1 : 2'd2);
			for (int s = 0; s < num_slots; s++)
				frame_ops[s] = 14'(s * 37 + 5);
			send_frame();
			wait_drain();
		end

		for (int ch = 0; ch < num_chan; ch++)
			set_chan(ch, 3'd7, 2'd3);
		for (int k = 0; k < 2; k++) begin
			for (int s = 0; s < num_slots; s++)
				frame_ops[s] = k ? 14'sh2000 : 14'sh1fff;  // Positive full scale first
			send_frame();
			wait_drain();
		end

		for (int k = 0; k < 4; k++) begin
			for (int ch = 0; ch < num_chan; ch++)
				set_chan(ch, 3'd0, 2'((ch + k) % 4));
			for (int s = 0; s < num_slots; s++)
				frame_ops[s] = 14'(s * 100 - 1500);
			send_frame();
			wait_drain();
		end

		for (int k = 0; k < 2; k++) begin
			set_noise(k == 0);                             // Channel 7 pans right here
			for (int s = 0; s < num_slots; s++)
				frame_ops[s] = 14'(s * 11);
			frame_noise = -10'sd301;
			send_frame();
			wait_drain();
		end

		for (int k = 0; k < 40; k++) begin
			for (int ch = 0; ch < num_chan; ch++)
				set_chan(ch, 3'($urandom), 2'($urandom));
			set_noise(1'($urandom));
			for (int s = 0; s < num_slots; s++)
				frame_ops[s] = 14'($urandom);
			frame_noise = 10'($urandom);
			send_frame();
			wait_drain();
		end

		wait_drain();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
